// ==== verilog/snn_pkg.sv ====
/*
 * Shared constants and helper functions for the spiking network synapse
 * initializer: generator width, feedback polynomial, seed rule, LFSR step
 */
package snn_pkg;

  ////////////////////////////////////////
  // Generator constants
  ////////////////////////////////////////

  // Width of every generator state
  localparam int LFSR_W = 16;

  // Galois feedback mask, x^16 + x^14 + x^13 + x^11 + 1
  localparam logic [LFSR_W-1:0] LFSR_POLY = 16'hB400;

  // Odd multiplier that spreads neighbouring seeds apart
  localparam logic [LFSR_W-1:0] SEED_STEP = 16'h9E37;

  // Seed bases of the two feed-forward projections
  localparam logic [LFSR_W-1:0] SEED_BASE_HIDDEN = 16'h5C70;
  localparam logic [LFSR_W-1:0] SEED_BASE_OUTPUT = 16'hDB82;

  ////////////////////////////////////////
  // Seed rule and LFSR step
  ////////////////////////////////////////

  // Seed of synapse number index inside a projection
  // A zero state would lock the generator, so fall back to the base
  function automatic logic [LFSR_W-1:0] lfsr_seed(
    input logic [LFSR_W-1:0] base,
    input int                index
  );
    logic [31:0]       prod;
    logic [LFSR_W-1:0] seed;
    prod = 32'(index + 1) * 32'(SEED_STEP);
    seed = base ^ prod[LFSR_W-1:0];
    if (seed == '0)
    begin
      seed = base;
    end
    return seed;
  endfunction

  // One right-shift Galois step
  function automatic logic [LFSR_W-1:0] lfsr_step(
    input logic [LFSR_W-1:0] state
  );
    logic [LFSR_W-1:0] next;
    next = state >> 1;
    if (state[0])
    begin
      next = next ^ LFSR_POLY;
    end
    return next;
  endfunction

endpackage

// ==== verilog/synapse_lfsr.sv ====
/*
 * Single synapse weight generator: a seeded Galois LFSR that steps once per
 * clock while active is high and presents a positive excitatory weight
 */
module synapse_lfsr #(
  parameter logic [snn_pkg::LFSR_W-1:0] SEED     = 16'h0001,
  parameter int                         WEIGHT_W = 16
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                active,
  output logic [WEIGHT_W-1:0] weight
);

  ////////////////////////////////////////
  // Generator state
  ////////////////////////////////////////

  logic [snn_pkg::LFSR_W-1:0] state_q;

  // Seed on reset, advance only while enabled
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= SEED;
    end
    else if (active)
    begin
      state_q <= snn_pkg::lfsr_step(state_q);
    end
  end

  ////////////////////////////////////////
  // Weight output
  ////////////////////////////////////////

  // Sign bit cleared so the weight is always excitatory
  assign weight = {1'b0, state_q[WEIGHT_W-2:0]};

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // A zero state never recovers, so the seed and every step must avoid it
  a_state_nonzero : assert property (
    @(posedge clk) disable iff (!rst_n)
    state_q != '0
  ) else $error("synapse_lfsr: generator state reached zero");

endmodule

// ==== verilog/projection_bank.sv ====
/*
 * Feed-forward projection between two layers: one weight generator per
 * (source, target) pair, packed source-major onto a flat weight bus
 */
module projection_bank #(
  parameter int                         N_SRC     = 6,
  parameter int                         N_DST     = 8,
  parameter logic [snn_pkg::LFSR_W-1:0] SEED_BASE = 16'h5C70,
  parameter int                         WEIGHT_W  = 16
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            active,
  output logic [N_SRC*N_DST*WEIGHT_W-1:0] weights
);

  localparam int N_SYN = N_SRC * N_DST;

  // Top bit of every slice, gathered for the sign check
  logic [N_SYN-1:0] sign_bits;

  ////////////////////////////////////////
  // Generator array
  ////////////////////////////////////////

  genvar s;
  genvar d;

  generate
    for (s = 0; s < N_SRC; s++)
    begin : g_src
      for (d = 0; d < N_DST; d++)
      begin : g_dst
        // Source-major synapse number, also used for the seed
        localparam int IDX = s * N_DST + d;

        synapse_lfsr #(
          .SEED     (snn_pkg::lfsr_seed(SEED_BASE, IDX)),
          .WEIGHT_W (WEIGHT_W)
        ) i_synapse_lfsr (
          .clk    (clk),
          .rst_n  (rst_n),
          .active (active),
          .weight (weights[IDX*WEIGHT_W +: WEIGHT_W])
        );

        assign sign_bits[IDX] = weights[IDX*WEIGHT_W + WEIGHT_W - 1];
      end
    end
  endgenerate

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Every random weight of the projection stays excitatory
  a_sign_clear : assert property (
    @(posedge clk) disable iff (!rst_n)
    sign_bits == '0
  ) else $error("projection_bank: negative weight on the bus");

  // Bus holds still on idle cycles
  a_hold_idle : assert property (
    @(posedge clk) disable iff (!rst_n)
    !active |=> $stable(weights)
  ) else $error("projection_bank: weights changed while idle");

endmodule

// ==== verilog/synapse_matrix.sv ====
/*
 * Synaptic matrix builder: places the random projections, lateral
 * inhibition and zero entries into one flat bus grouped by target neuron
 */
module synapse_matrix #(
  parameter int N_INPUT  = 6,
  parameter int N_HIDDEN = 8,
  parameter int N_OUTPUT = 2,
  parameter int WEIGHT_W = 16
) (
  input  logic [N_INPUT*N_HIDDEN*WEIGHT_W-1:0]  hidden_weights,
  input  logic [N_HIDDEN*N_OUTPUT*WEIGHT_W-1:0] output_weights,
  output logic [(N_INPUT+N_HIDDEN+N_OUTPUT)*(N_INPUT+N_HIDDEN+N_OUTPUT)*WEIGHT_W-1:0]
               synapses_value
);

  // Total neuron count and first index of each layer
  localparam int N     = N_INPUT + N_HIDDEN + N_OUTPUT;
  localparam int HID_0 = N_INPUT;
  localparam int OUT_0 = N_INPUT + N_HIDDEN;

  // Inhibitory weight, only the top bit set
  localparam logic [WEIGHT_W-1:0] INH_WEIGHT = {1'b1, {(WEIGHT_W-1){1'b0}}};

  ////////////////////////////////////////
  // Entry classification
  ////////////////////////////////////////

  genvar tgt;
  genvar src;

  generate
    for (tgt = 0; tgt < N; tgt++)
    begin : g_tgt
      for (src = 0; src < N; src++)
      begin : g_src
        // Slice of this entry in the target-grouped output
        localparam int SLOT = tgt * N + src;

        localparam bit SRC_IN  = src < HID_0;
        localparam bit SRC_HID = (src >= HID_0) && (src < OUT_0);
        localparam bit SRC_OUT = src >= OUT_0;
        localparam bit TGT_HID = (tgt >= HID_0) && (tgt < OUT_0);
        localparam bit TGT_OUT = tgt >= OUT_0;

        if (SRC_IN && TGT_HID)
        begin : g_in_hid
          // Input to hidden, bank is source-major
          localparam int BANK_IDX = src * N_HIDDEN + (tgt - HID_0);
          assign synapses_value[SLOT*WEIGHT_W +: WEIGHT_W] =
            hidden_weights[BANK_IDX*WEIGHT_W +: WEIGHT_W];
        end
        else if (SRC_HID && TGT_OUT)
        begin : g_hid_out
          // Hidden to output
          localparam int BANK_IDX = (src - HID_0) * N_OUTPUT + (tgt - OUT_0);
          assign synapses_value[SLOT*WEIGHT_W +: WEIGHT_W] =
            output_weights[BANK_IDX*WEIGHT_W +: WEIGHT_W];
        end
        else if (src != tgt && ((SRC_HID && TGT_HID) || (SRC_OUT && TGT_OUT)))
        begin : g_lateral
          // Lateral inhibition inside hidden or output layer
          assign synapses_value[SLOT*WEIGHT_W +: WEIGHT_W] = INH_WEIGHT;
        end
        else
        begin : g_zero
          // Self, input-to-input, backward and input-to-output links
          assign synapses_value[SLOT*WEIGHT_W +: WEIGHT_W] = '0;
        end
      end
    end
  endgenerate

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Entry from the first hidden neuron to the second, found by the raw
  // target-grouped index rather than through the generate tree
  generate
    if (N_HIDDEN > 1)
    begin : g_inh_check
      localparam int CHECK_SLOT = (HID_0 + 1) * N + HID_0;
      localparam int DIAG_SLOT  = HID_0 * N + HID_0;

      always_comb
      begin
        a_hidden_inh : assert (
          synapses_value[CHECK_SLOT*WEIGHT_W +: WEIGHT_W] == INH_WEIGHT &&
          synapses_value[DIAG_SLOT*WEIGHT_W +: WEIGHT_W] == '0
        ) else $error("synapse_matrix: hidden inhibition misplaced");
      end
    end
  endgenerate

endmodule

// ==== verilog/synapse_init.sv ====
/*
 * Top level of the synapse initializer: two feed-forward projection banks
 * feeding the matrix builder that emits the full synaptic weight matrix
 */
module synapse_init #(
  parameter int N_INPUT  = 6,
  parameter int N_HIDDEN = 8,
  parameter int N_OUTPUT = 2,
  parameter int WEIGHT_W = 16
) (
  input  logic clk,
  input  logic rst_n,
  input  logic active,
  output logic [(N_INPUT+N_HIDDEN+N_OUTPUT)*(N_INPUT+N_HIDDEN+N_OUTPUT)*WEIGHT_W-1:0]
               synapses_value
);

  // Weight needs a sign bit plus at least one state bit
  generate
    if (WEIGHT_W < 2 || WEIGHT_W > snn_pkg::LFSR_W + 1)
    begin : g_width_check
      $error("synapse_init: WEIGHT_W must lie between 2 and LFSR_W + 1");
    end
  endgenerate

  ////////////////////////////////////////
  // Projection buses
  ////////////////////////////////////////

  logic [N_INPUT*N_HIDDEN*WEIGHT_W-1:0]  hidden_weights;
  logic [N_HIDDEN*N_OUTPUT*WEIGHT_W-1:0] output_weights;

  // Input layer to hidden layer
  projection_bank #(
    .N_SRC     (N_INPUT),
    .N_DST     (N_HIDDEN),
    .SEED_BASE (snn_pkg::SEED_BASE_HIDDEN),
    .WEIGHT_W  (WEIGHT_W)
  ) i_hidden_bank (
    .clk     (clk),
    .rst_n   (rst_n),
    .active  (active),
    .weights (hidden_weights)
  );

  // Hidden layer to output layer
  projection_bank #(
    .N_SRC     (N_HIDDEN),
    .N_DST     (N_OUTPUT),
    .SEED_BASE (snn_pkg::SEED_BASE_OUTPUT),
    .WEIGHT_W  (WEIGHT_W)
  ) i_output_bank (
    .clk     (clk),
    .rst_n   (rst_n),
    .active  (active),
    .weights (output_weights)
  );

  ////////////////////////////////////////
  // Matrix assembly
  ////////////////////////////////////////

  synapse_matrix #(
    .N_INPUT  (N_INPUT),
    .N_HIDDEN (N_HIDDEN),
    .N_OUTPUT (N_OUTPUT),
    .WEIGHT_W (WEIGHT_W)
  ) i_synapse_matrix (
    .hidden_weights (hidden_weights),
    .output_weights (output_weights),
    .synapses_value (synapses_value)
  );

endmodule

// ==== tests/synapse_model.svh ====
/*
 * Reference model of the synapse initializer: one state per feed-forward
 * synapse, the seed rule, the Galois step and the target-grouped layout
 */
`ifndef SYNAPSE_MODEL_SVH
`define SYNAPSE_MODEL_SVH

// Generator constants
localparam logic [15:0] GEN_POLY  = 16'hB400;
localparam logic [15:0] SPREAD    = 16'h9E37;
localparam logic [15:0] BASE_HID  = 16'h5C70;
localparam logic [15:0] BASE_OUT  = 16'hDB82;

// Model state, source-major like the projection buses
logic [15:0] hid_state [N_INPUT*N_HIDDEN];
logic [15:0] out_state [N_HIDDEN*N_OUTPUT];

// Base XOR (index + 1) times the spread constant, base again if that gives zero
function automatic logic [15:0] seed_for(input logic [15:0] base, input int index);
  logic [31:0] mult;
  logic [15:0] s;
  mult = 32'(index + 1) * {16'h0000, SPREAD};
  s = base ^ mult[15:0];
  if (s == 16'h0000)
  begin
    s = base;
  end
  return s;
endfunction

function automatic logic [15:0] next_state(input logic [15:0] st);
  return st[0] ? ((st >> 1) ^ GEN_POLY) : (st >> 1);
endfunction

task automatic load_seeds();
  for (int i = 0; i < N_INPUT * N_HIDDEN; i++)
  begin
    hid_state[i] = seed_for(BASE_HID, i);
  end
  for (int i = 0; i < N_HIDDEN * N_OUTPUT; i++)
  begin
    out_state[i] = seed_for(BASE_OUT, i);
  end
endtask

task automatic advance_states();
  for (int i = 0; i < N_INPUT * N_HIDDEN; i++)
  begin
    hid_state[i] = next_state(hid_state[i]);
  end
  for (int i = 0; i < N_HIDDEN * N_OUTPUT; i++)
  begin
    out_state[i] = next_state(out_state[i]);
  end
endtask

// 0 input, 1 hidden, 2 output
function automatic int layer_of(input int n);
  if (n < N_INPUT)
  begin
    return 0;
  end
  return (n < N_INPUT + N_HIDDEN) ? 1 : 2;
endfunction

function automatic logic [WEIGHT_W-1:0] expected_entry(input int tgt, input int src);
  logic [15:0]         st;
  logic [WEIGHT_W-1:0] w;
  w = '0;
  if (layer_of(src) == 0 && layer_of(tgt) == 1)
  begin
    st = hid_state[src * N_HIDDEN + (tgt - N_INPUT)];
    w = {1'b0, st[WEIGHT_W-2:0]};
  end
  else if (layer_of(src) == 1 && layer_of(tgt) == 2)
  begin
    st = out_state[(src - N_INPUT) * N_OUTPUT + (tgt - N_INPUT - N_HIDDEN)];
    w = {1'b0, st[WEIGHT_W-2:0]};
  end
  else if (src != tgt && layer_of(src) == layer_of(tgt) && layer_of(src) != 0)
  begin
    // Lateral inhibition
    w = {1'b1, {(WEIGHT_W-1){1'b0}}};
  end
  return w;
endfunction

`endif

// ==== tests/tb_synapse_init.sv ====
/*
 * Testbench for the synapse initializer: random active levels against a
 * reference model, full matrix compared after every clock
 */
module tb_synapse_init;

  localparam int N_INPUT  = 6;
  localparam int N_HIDDEN = 8;
  localparam int N_OUTPUT = 2;
  localparam int WEIGHT_W = 16;
  localparam int N        = N_INPUT + N_HIDDEN + N_OUTPUT;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int IDLE_CYCLES  = 3;
  localparam int N_CYCLES     = 2000;
  localparam int SEED         = 32'h2b96;

  // Reset, idle and random cycles plus a little slack
  localparam int TOTAL_CYCLES    = RESET_CYCLES + IDLE_CYCLES + N_CYCLES + 2;
  localparam int TIMEOUT         = TOTAL_CYCLES * CLK_PERIOD * 3 / 2;

  logic                      clk;
  logic                      rst_n;
  logic                      active;
  logic [N*N*WEIGHT_W-1:0]   synapses_value;

  int active_cycles;

  `include "synapse_model.svh"

  synapse_init #(
    .N_INPUT  (N_INPUT),
    .N_HIDDEN (N_HIDDEN),
    .N_OUTPUT (N_OUTPUT),
    .WEIGHT_W (WEIGHT_W)
  ) i_synapse_init (
    .clk            (clk),
    .rst_n          (rst_n),
    .active         (active),
    .synapses_value (synapses_value)
  );

  ////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(TIMEOUT);
    $display("Timeout: the run did not reach its end in %0d time units", TIMEOUT);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////
  // Matrix comparison
  ////////////////////////////////////////

  // Every slice at target * N + source against the model
  task automatic compare_matrix();
    logic [WEIGHT_W-1:0] got;
    logic [WEIGHT_W-1:0] exp;
    for (int t = 0; t < N; t++)
    begin
      for (int s = 0; s < N; s++)
      begin
        got = synapses_value[(t*N + s)*WEIGHT_W +: WEIGHT_W];
        exp = expected_entry(t, s);
        a_entry : assert (got === exp)
        else
        begin
          $display("CHECK FAILED at %0t: target %0d source %0d got %h expected %h",
                   $time, t, s, got, exp);
          $display("ERRORS FOUND");
          $fatal(1, "matrix entry mismatch");
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial
  begin
    logic step_en;
    void'($urandom(SEED));
    rst_n         = 1'b0;
    active        = 1'b0;
    active_cycles = 0;
    load_seeds();

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    // Generators sit at their seeds while reset is held
    compare_matrix();
    rst_n = 1'b1;

    // Nothing may move before the first active cycle
    repeat (IDLE_CYCLES)
    begin
      @(negedge clk);
      compare_matrix();
    end

    for (int c = 0; c < N_CYCLES; c++)
    begin
      step_en = ($urandom % 100) < 60;
      active  = step_en;
      @(posedge clk);
      if (step_en)
      begin
        advance_states();
        active_cycles++;
      end
      @(negedge clk);
      compare_matrix();
    end

    active = 1'b0;
    $display("Ran %0d cycles, %0d of them active", N_CYCLES, active_cycles);

    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+tests
verilog/snn_pkg.sv
verilog/synapse_lfsr.sv
verilog/projection_bank.sv
verilog/synapse_matrix.sv
verilog/synapse_init.sv
tests/tb_synapse_init.sv

// ==== Makefile ====
TOP = tb_synapse_init

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
